// ==== hdl/ntt_pkg.sv ====
// shared constants, coefficient type, mode encoding and modular add/sub for the ntt butterfly array
package ntt_pkg;

    // --------------------------------------------------
    // field parameters
    // --------------------------------------------------
    // ml-dsa prime, 2^23 - 2^13 + 1
    parameter int unsigned NTT_Q = 8380417;
    parameter int unsigned COEFF_W = 23;

    typedef logic [COEFF_W-1:0] coeff_t;

    // butterfly operating modes
    typedef enum logic [2:0] {
        ct  = 3'd0,
        gs  = 3'd1,
        pwm = 3'd2,
        pwa = 3'd3,
        pws = 3'd4
    } ntt_mode_e;

    // --------------------------------------------------
    // pipeline latencies in clock cycles
    // --------------------------------------------------
    // product register then reduction register
    parameter int unsigned MUL_LATENCY = 2;
    // input reg, multiplier, output add/sub reg
    parameter int unsigned BF_LATENCY = MUL_LATENCY + 2;
    // input reg, multiplier result used directly
    parameter int unsigned PWM_LATENCY = MUL_LATENCY + 1;
    // one add or subtract register
    parameter int unsigned PWAS_LATENCY = 1;
    // two butterfly layers back to back
    parameter int unsigned NTT_LATENCY = 2 * BF_LATENCY;

    // --------------------------------------------------
    // modular helpers, operands assumed below q
    // --------------------------------------------------
    function automatic coeff_t mod_add(input coeff_t a, input coeff_t b,
                                       input logic [COEFF_W:0] q);
        logic [COEFF_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        // at most one correction needed
        if (sum >= q) begin
            sum = sum - q;
        end
        return sum[COEFF_W-1:0];
    endfunction

    function automatic coeff_t mod_sub(input coeff_t a, input coeff_t b,
                                       input logic [COEFF_W:0] q);
        logic [COEFF_W:0] diff;
        diff = {1'b0, a} - {1'b0, b};
        // borrow bit set, wrap back into range
        if (diff[COEFF_W]) begin
            diff = diff + q;
        end
        return diff[COEFF_W-1:0];
    endfunction

endpackage

// ==== hdl/ntt_operand_if.sv ====
// operand bundle for one butterfly, driven by the router and read by a butterfly
`timescale 1ns/10ps

interface ntt_operand_if;
    import ntt_pkg::*;

    // butterfly inputs
    coeff_t u;
    coeff_t v;
    // twiddle, unused in point-wise modes
    coeff_t w;
    ntt_mode_e mode;

    // router side
    modport router_mp (
        output u,
        output v,
        output w,
        output mode
    );

    // butterfly side
    modport bf_mp (
        input u,
        input v,
        input w,
        input mode
    );

endinterface

// ==== hdl/ntt_mod_mult.sv ====
// two-stage pipelined modular multiplier, product register followed by reduction register
`timescale 1ns/10ps

module ntt_mod_mult #(
    parameter int unsigned COEFF_Q = ntt_pkg::NTT_Q
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            zeroize_i,
    input  ntt_pkg::coeff_t a_i,
    input  ntt_pkg::coeff_t b_i,
    output ntt_pkg::coeff_t p_o
);
    import ntt_pkg::*;

    localparam int unsigned PROD_W = 2 * COEFF_W;
    localparam logic [PROD_W-1:0] Q_EXT = PROD_W'(COEFF_Q);

    // full 46-bit product
    logic [PROD_W-1:0] prod_q;

    // --------------------------------------------------
    // stage 1, raw product
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
        end else if (zeroize_i) begin
            prod_q <= '0;
        end else begin
            prod_q <= a_i * b_i;
        end
    end

    // --------------------------------------------------
    // stage 2, reduce mod q
    // --------------------------------------------------
    // remainder always fits the coefficient width
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            p_o <= '0;
        end else if (zeroize_i) begin
            p_o <= '0;
        end else begin
            p_o <= COEFF_W'(prod_q % Q_EXT);
        end
    end

endmodule

// ==== hdl/ntt_butterfly.sv ====
// single radix-2 butterfly for ct, gs and the point-wise modes, fixed latency per mode
`timescale 1ns/10ps

module ntt_butterfly #(
    parameter int unsigned COEFF_Q       = ntt_pkg::NTT_Q,
    parameter int unsigned STAGE_LATENCY = ntt_pkg::BF_LATENCY
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    ntt_operand_if.bf_mp        op,
    output ntt_pkg::coeff_t     u_o,
    output ntt_pkg::coeff_t     v_o,
    output ntt_pkg::coeff_t     r_o
);
    import ntt_pkg::*;

    localparam logic [COEFF_W:0] Q_EXT = (COEFF_W+1)'(COEFF_Q);
    // input and output registers wrap the multiplier
    localparam int unsigned A_DLY = STAGE_LATENCY - 2;

    coeff_t sum_c, dif_c;
    coeff_t a_c, b_c, w_c;
    coeff_t a_q, b_q, w_q;
    coeff_t a_dly [A_DLY];
    coeff_t p;

    // --------------------------------------------------
    // input stage operand select
    // --------------------------------------------------
    always_comb begin
        sum_c = mod_add(op.u, op.v, Q_EXT);
        dif_c = mod_sub(op.u, op.v, Q_EXT);
        a_c = '0;
        b_c = '0;
        w_c = '0;
        case (op.mode)
            // w*v goes to mult, u waits
            ct: begin
                a_c = op.u;
                b_c = op.v;
                w_c = op.w;
            end
            // sum waits, difference goes to mult
            gs: begin
                a_c = sum_c;
                b_c = dif_c;
                w_c = op.w;
            end
            // u*v through the same mult port
            pwm: begin
                b_c = op.v;
                w_c = op.u;
            end
            pwa: a_c = sum_c;
            pws: a_c = dif_c;
            default: a_c = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            a_q <= '0;
            b_q <= '0;
            w_q <= '0;
        end else if (zeroize_i) begin
            a_q <= '0;
            b_q <= '0;
            w_q <= '0;
        end else begin
            a_q <= a_c;
            b_q <= b_c;
            w_q <= w_c;
        end
    end

    // --------------------------------------------------
    // multiplier and matching delay for a
    // --------------------------------------------------
    ntt_mod_mult #(
        .COEFF_Q (COEFF_Q)
    ) mult_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (w_q),
        .b_i       (b_q),
        .p_o       (p)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < A_DLY; i++) begin
                a_dly[i] <= '0;
            end
        end else if (zeroize_i) begin
            for (int i = 0; i < A_DLY; i++) begin
                a_dly[i] <= '0;
            end
        end else begin
            a_dly[0] <= a_q;
            for (int i = 1; i < A_DLY; i++) begin
                a_dly[i] <= a_dly[i-1];
            end
        end
    end

    // --------------------------------------------------
    // output stage
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            u_o <= '0;
            v_o <= '0;
        end else if (zeroize_i) begin
            u_o <= '0;
            v_o <= '0;
        end else if (op.mode == ct) begin
            u_o <= mod_add(a_dly[A_DLY-1], p, Q_EXT);
            v_o <= mod_sub(a_dly[A_DLY-1], p, Q_EXT);
        end else if (op.mode == gs) begin
            u_o <= a_dly[A_DLY-1];
            v_o <= p;
        end
    end

    // point-wise result, straight from mult or from input reg
    always_comb begin
        case (op.mode)
            pwm:      r_o = p;
            pwa, pws: r_o = a_q;
            default:  r_o = '0;
        endcase
    end

endmodule

// ==== hdl/ntt_operand_router.sv ====
// input side of the butterfly array, steers operands per mode and aligns stage-2 twiddles
`timescale 1ns/10ps

module ntt_operand_router #(
    parameter int unsigned STAGE_LATENCY = ntt_pkg::BF_LATENCY
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 zeroize_i,
    input  ntt_pkg::ntt_mode_e   mode_i,
    // first layer operands
    input  ntt_pkg::coeff_t      u00_i,
    input  ntt_pkg::coeff_t      v00_i,
    input  ntt_pkg::coeff_t      w00_i,
    input  ntt_pkg::coeff_t      u01_i,
    input  ntt_pkg::coeff_t      v01_i,
    input  ntt_pkg::coeff_t      w01_i,
    // second layer twiddles, sampled with the first layer
    input  ntt_pkg::coeff_t      w10_i,
    input  ntt_pkg::coeff_t      w11_i,
    // point-wise operand pairs
    input  ntt_pkg::coeff_t      pw_u_i [4],
    input  ntt_pkg::coeff_t      pw_v_i [4],
    // stage-1 results fed back
    input  ntt_pkg::coeff_t      u10_int_i,
    input  ntt_pkg::coeff_t      u11_int_i,
    input  ntt_pkg::coeff_t      v10_int_i,
    input  ntt_pkg::coeff_t      v11_int_i,
    ntt_operand_if.router_mp     op00,
    ntt_operand_if.router_mp     op01,
    ntt_operand_if.router_mp     op10,
    ntt_operand_if.router_mp     op11
);
    import ntt_pkg::*;

    logic pw_mode;
    // index 0 is the oldest twiddle
    coeff_t w10_sr [STAGE_LATENCY];
    coeff_t w11_sr [STAGE_LATENCY];

    assign pw_mode = (mode_i inside {pwm, pwa, pws});

    // --------------------------------------------------
    // twiddle delay, one stage-1 butterfly deep
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < STAGE_LATENCY; i++) begin
                w10_sr[i] <= '0;
                w11_sr[i] <= '0;
            end
        end else if (zeroize_i) begin
            for (int i = 0; i < STAGE_LATENCY; i++) begin
                w10_sr[i] <= '0;
                w11_sr[i] <= '0;
            end
        end else begin
            w10_sr[STAGE_LATENCY-1] <= w10_i;
            w11_sr[STAGE_LATENCY-1] <= w11_i;
            for (int i = 0; i < STAGE_LATENCY - 1; i++) begin
                w10_sr[i] <= w10_sr[i+1];
                w11_sr[i] <= w11_sr[i+1];
            end
        end
    end

    // --------------------------------------------------
    // operand steering
    // --------------------------------------------------
    always_comb begin
        op00.mode = mode_i;
        op01.mode = mode_i;
        op10.mode = mode_i;
        op11.mode = mode_i;
        if (pw_mode) begin
            // four independent pairs, no twiddle
            op00.u = pw_u_i[0];
            op00.v = pw_v_i[0];
            op00.w = '0;
            op01.u = pw_u_i[1];
            op01.v = pw_v_i[1];
            op01.w = '0;
            op10.u = pw_u_i[2];
            op10.v = pw_v_i[2];
            op10.w = '0;
            op11.u = pw_u_i[3];
            op11.v = pw_v_i[3];
            op11.w = '0;
        end else begin
            op00.u = u00_i;
            op00.v = v00_i;
            op00.w = w00_i;
            op01.u = u01_i;
            op01.v = v01_i;
            op01.w = w01_i;
            // second layer takes stage-1 outputs
            op10.u = u10_int_i;
            op10.v = v10_int_i;
            op10.w = w10_sr[0];
            op11.u = u11_int_i;
            op11.v = v11_int_i;
            op11.w = w11_sr[0];
        end
    end

endmodule

// ==== hdl/ntt_ready_tracker.sv ====
// output side of the butterfly array, delays each enable pulse into a ready pulse per mode
`timescale 1ns/10ps

module ntt_ready_tracker (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize_i,
    input  ntt_pkg::ntt_mode_e mode_i,
    input  logic               enable_i,
    output logic               ready_o
);
    import ntt_pkg::*;

    // bit 0 is the ready bit, shifts down each cycle
    logic [NTT_LATENCY-1:0] rdy_sr;
    logic [NTT_LATENCY-1:0] ins_vec;

    // --------------------------------------------------
    // insert position by mode latency
    // --------------------------------------------------
    always_comb begin
        ins_vec = '0;
        case (mode_i)
            ct, gs:   ins_vec[NTT_LATENCY-1]  = enable_i;
            pwm:      ins_vec[PWM_LATENCY-1]  = enable_i;
            pwa, pws: ins_vec[PWAS_LATENCY-1] = enable_i;
            default:  ins_vec = '0;
        endcase
    end

    // overlapping pulses keep their own slots
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rdy_sr <= '0;
        end else if (zeroize_i) begin
            rdy_sr <= '0;
        end else begin
            rdy_sr <= (rdy_sr >> 1) | ins_vec;
        end
    end

    assign ready_o = rdy_sr[0];

endmodule

// ==== hdl/ntt_butterfly_2x2.sv ====
// top level 2x2 butterfly array for ml-dsa ntt, intt and point-wise ops with plain ports
`timescale 1ns/10ps

module ntt_butterfly_2x2 #(
    parameter int unsigned COEFF_Q       = ntt_pkg::NTT_Q,
    parameter int unsigned STAGE_LATENCY = ntt_pkg::BF_LATENCY
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize_i,
    input  ntt_pkg::ntt_mode_e mode_i,
    input  logic               enable_i,
    // butterfly operands
    input  ntt_pkg::coeff_t    u00_i,
    input  ntt_pkg::coeff_t    v00_i,
    input  ntt_pkg::coeff_t    w00_i,
    input  ntt_pkg::coeff_t    u01_i,
    input  ntt_pkg::coeff_t    v01_i,
    input  ntt_pkg::coeff_t    w01_i,
    input  ntt_pkg::coeff_t    w10_i,
    input  ntt_pkg::coeff_t    w11_i,
    // point-wise operands
    input  ntt_pkg::coeff_t    pw_u_i [4],
    input  ntt_pkg::coeff_t    pw_v_i [4],
    // second layer results
    output ntt_pkg::coeff_t    u20_o,
    output ntt_pkg::coeff_t    v20_o,
    output ntt_pkg::coeff_t    u21_o,
    output ntt_pkg::coeff_t    v21_o,
    // point-wise results
    output ntt_pkg::coeff_t    pwo0_o,
    output ntt_pkg::coeff_t    pwo1_o,
    output ntt_pkg::coeff_t    pwo2_o,
    output ntt_pkg::coeff_t    pwo3_o,
    output logic               ready_o
);
    import ntt_pkg::*;

    // stage-1 results back to the router
    coeff_t u10_int, u11_int, v10_int, v11_int;

    ntt_operand_if op00 ();
    ntt_operand_if op01 ();
    ntt_operand_if op10 ();
    ntt_operand_if op11 ();

    // --------------------------------------------------
    // input side
    // --------------------------------------------------
    ntt_operand_router #(
        .STAGE_LATENCY (STAGE_LATENCY)
    ) router_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (mode_i),
        .u00_i     (u00_i),
        .v00_i     (v00_i),
        .w00_i     (w00_i),
        .u01_i     (u01_i),
        .v01_i     (v01_i),
        .w01_i     (w01_i),
        .w10_i     (w10_i),
        .w11_i     (w11_i),
        .pw_u_i    (pw_u_i),
        .pw_v_i    (pw_v_i),
        .u10_int_i (u10_int),
        .u11_int_i (u11_int),
        .v10_int_i (v10_int),
        .v11_int_i (v11_int),
        .op00      (op00),
        .op01      (op01),
        .op10      (op10),
        .op11      (op11)
    );

    // --------------------------------------------------
    // first layer
    // --------------------------------------------------
    // bf00 outputs cross to both second layer units
    ntt_butterfly #(.COEFF_Q(COEFF_Q), .STAGE_LATENCY(STAGE_LATENCY)) bf00 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .op(op00),
        .u_o(u10_int), .v_o(u11_int), .r_o(pwo0_o)
    );

    ntt_butterfly #(.COEFF_Q(COEFF_Q), .STAGE_LATENCY(STAGE_LATENCY)) bf01 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .op(op01),
        .u_o(v10_int), .v_o(v11_int), .r_o(pwo1_o)
    );

    // --------------------------------------------------
    // second layer
    // --------------------------------------------------
    ntt_butterfly #(.COEFF_Q(COEFF_Q), .STAGE_LATENCY(STAGE_LATENCY)) bf10 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .op(op10),
        .u_o(u20_o), .v_o(v20_o), .r_o(pwo2_o)
    );

    ntt_butterfly #(.COEFF_Q(COEFF_Q), .STAGE_LATENCY(STAGE_LATENCY)) bf11 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .op(op11),
        .u_o(u21_o), .v_o(v21_o), .r_o(pwo3_o)
    );

    // --------------------------------------------------
    // ready strobe
    // --------------------------------------------------
    ntt_ready_tracker tracker_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (mode_i),
        .enable_i  (enable_i),
        .ready_o   (ready_o)
    );

endmodule

// ==== verif/tb_ntt_model.svh ====
// reference mod q arithmetic, stimulus lfsr and value check included by the butterfly testbench
`ifndef TB_NTT_MODEL_SVH
`define TB_NTT_MODEL_SVH

// --------------------------------------------------
// reference arithmetic in plain 64 bits
// --------------------------------------------------
localparam logic [63:0] REF_Q = 64'd8380417;

function automatic logic [63:0] ref_add(input logic [63:0] a, input logic [63:0] b);
    return (a + b) % REF_Q;
endfunction

// wraps through q when b exceeds a
function automatic logic [63:0] ref_sub(input logic [63:0] a, input logic [63:0] b);
    return (a + REF_Q - b) % REF_Q;
endfunction

// product stays below 2^46
function automatic logic [63:0] ref_mul(input logic [63:0] a, input logic [63:0] b);
    return (a * b) % REF_Q;
endfunction

// cooley-tukey pair
function automatic void ref_ct(input logic [63:0] u, input logic [63:0] v,
                               input logic [63:0] w, output logic [63:0] hi,
                               output logic [63:0] lo);
    logic [63:0] t;
    t = ref_mul(w, v);
    hi = ref_add(u, t);
    lo = ref_sub(u, t);
endfunction

// gentleman-sande pair
function automatic void ref_gs(input logic [63:0] u, input logic [63:0] v,
                               input logic [63:0] w, output logic [63:0] hi,
                               output logic [63:0] lo);
    hi = ref_add(u, v);
    lo = ref_mul(ref_sub(u, v), w);
endfunction

// --------------------------------------------------
// stimulus lfsr
// --------------------------------------------------
// fibonacci form with taps 32 22 2 1
logic [31:0] lfsr_state = 32'd76397;

function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

// 23 fresh bits folded below q
function automatic logic [63:0] rand_coeff();
    logic [63:0] val;
    val = '0;
    for (int b = 0; b < 23; b++) begin
        val = {val[62:0], lfsr_bit()};
    end
    return val % REF_Q;
endfunction

// --------------------------------------------------
// value compare
// --------------------------------------------------
task automatic check_value(input string tname, input logic [63:0] expected,
                           input logic [63:0] actual);
    if (expected !== actual) begin
        $display("** Error %s: expected %0d, actual %0d", tname, expected, actual);
        $display("Regression failed");
        $fatal(1, "value mismatch");
    end
endtask

`endif

// ==== verif/tb_ntt_butterfly_2x2.sv ====
// testbench for the 2x2 ntt butterfly array running directed ct gs point-wise and zeroize tests
`timescale 1ns/10ps

module tb_ntt_butterfly_2x2;
    import ntt_pkg::*;

    localparam int MAX_ITEMS = 32;
    // ready delay after the enable cycle for each mode
    localparam int NTT_READY_LAT = 8;
    localparam int PWM_READY_LAT = 3;
    localparam int PWAS_READY_LAT = 1;
    // five streams of 20 plus the zeroize fill
    localparam int TOTAL_ITEMS = 5 * 20 + 6;
    localparam int TIMEOUT_CYCLES = 16 + TOTAL_ITEMS * (NTT_READY_LAT + 2) + 100;

    logic      clk;
    logic      reset_n;
    logic      zeroize_i;
    ntt_mode_e mode_i;
    logic      enable_i;
    coeff_t    u00_i, v00_i, w00_i, u01_i, v01_i, w01_i, w10_i, w11_i;
    coeff_t    pw_u_i [4];
    coeff_t    pw_v_i [4];
    coeff_t    u20_o, v20_o, u21_o, v21_o;
    coeff_t    pwo0_o, pwo1_o, pwo2_o, pwo3_o;
    logic      ready_o;

    // per item operands
    // ntt order u00 v00 w00 u01 v01 w01 w10 w11
    // point-wise order pw_u 0..3 then pw_v 0..3
    logic [63:0] stim [MAX_ITEMS][8];
    logic [63:0] expv [MAX_ITEMS][4];
    int          items_checked;
    int          cycle_cnt;

    `include "tb_ntt_model.svh"

    ntt_butterfly_2x2 uut (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .mode_i(mode_i),
        .enable_i(enable_i), .u00_i(u00_i), .v00_i(v00_i), .w00_i(w00_i),
        .u01_i(u01_i), .v01_i(v01_i), .w01_i(w01_i), .w10_i(w10_i), .w11_i(w11_i),
        .pw_u_i(pw_u_i), .pw_v_i(pw_v_i), .u20_o(u20_o), .v20_o(v20_o),
        .u21_o(u21_o), .v21_o(v21_o), .pwo0_o(pwo0_o), .pwo1_o(pwo1_o),
        .pwo2_o(pwo2_o), .pwo3_o(pwo3_o), .ready_o(ready_o)
    );

    // --------------------------------------------------
    // clock and run limit
    // --------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Regression failed");
            $fatal(1, "simulation timed out");
        end
    end

    // --------------------------------------------------
    // stimulus helpers
    // --------------------------------------------------
    task automatic zero_inputs();
        mode_i   <= ct;
        enable_i <= 1'b0;
        {u00_i, v00_i, w00_i, u01_i} <= '0;
        {v01_i, w01_i, w10_i, w11_i} <= '0;
        for (int k = 0; k < 4; k++) begin
            pw_u_i[k] <= '0;
            pw_v_i[k] <= '0;
        end
    endtask

    task automatic release_reset();
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
    endtask

    function automatic void fill_random(input int n);
        for (int i = 0; i < n; i++) begin
            for (int j = 0; j < 8; j++) begin
                stim[i][j] = rand_coeff();
            end
        end
    endfunction

    // one point-wise lane of one item
    function automatic void set_pair(input int i, input int k, input logic [63:0] u,
                                     input logic [63:0] v);
        stim[i][k] = u;
        stim[i][4 + k] = v;
    endfunction

    task automatic drive_item(input ntt_mode_e mode, input int i);
        mode_i   <= mode;
        enable_i <= 1'b1;
        if (mode == ct || mode == gs) begin
            u00_i <= coeff_t'(stim[i][0]);
            v00_i <= coeff_t'(stim[i][1]);
            w00_i <= coeff_t'(stim[i][2]);
            u01_i <= coeff_t'(stim[i][3]);
            v01_i <= coeff_t'(stim[i][4]);
            w01_i <= coeff_t'(stim[i][5]);
            w10_i <= coeff_t'(stim[i][6]);
            w11_i <= coeff_t'(stim[i][7]);
        end else begin
            for (int k = 0; k < 4; k++) begin
                pw_u_i[k] <= coeff_t'(stim[i][k]);
                pw_v_i[k] <= coeff_t'(stim[i][4 + k]);
            end
        end
    endtask

    // two layers for ntt modes and four lanes for point-wise modes
    function automatic void compute_expected(input ntt_mode_e mode, input int n);
        logic [63:0] a0, b0, a1, b1;
        for (int i = 0; i < n; i++) begin
            if (mode == ct) begin
                ref_ct(stim[i][0], stim[i][1], stim[i][2], a0, b0);
                ref_ct(stim[i][3], stim[i][4], stim[i][5], a1, b1);
                ref_ct(a0, a1, stim[i][6], expv[i][0], expv[i][1]);
                ref_ct(b0, b1, stim[i][7], expv[i][2], expv[i][3]);
            end else if (mode == gs) begin
                ref_gs(stim[i][0], stim[i][1], stim[i][2], a0, b0);
                ref_gs(stim[i][3], stim[i][4], stim[i][5], a1, b1);
                ref_gs(a0, a1, stim[i][6], expv[i][0], expv[i][1]);
                ref_gs(b0, b1, stim[i][7], expv[i][2], expv[i][3]);
            end else begin
                for (int k = 0; k < 4; k++) begin
                    if (mode == pwm) begin
                        expv[i][k] = ref_mul(stim[i][k], stim[i][4 + k]);
                    end else if (mode == pwa) begin
                        expv[i][k] = ref_add(stim[i][k], stim[i][4 + k]);
                    end else begin
                        expv[i][k] = ref_sub(stim[i][k], stim[i][4 + k]);
                    end
                end
            end
        end
    endfunction

    // --------------------------------------------------
    // checkers
    // --------------------------------------------------
    // one enable per cycle and ready due exactly lat cycles later
    task automatic stream_items(input ntt_mode_e mode, input int n, input string name);
        int    lat;
        int    idx;
        logic  ntt;
        string tag;
        ntt = (mode == ct) || (mode == gs);
        lat = ntt ? NTT_READY_LAT : ((mode == pwm) ? PWM_READY_LAT : PWAS_READY_LAT);
        compute_expected(mode, n);
        for (int s = 0; s <= n + lat; s++) begin
            @(posedge clk);
            if (s < n) begin
                drive_item(mode, s);
            end else begin
                enable_i <= 1'b0;
            end
            // outputs settled well before the falling edge
            @(negedge clk);
            idx = s - lat;
            if (idx >= 0 && idx < n) begin
                if (!ready_o) begin
                    $display("Regression failed");
                    $fatal(1, "ready missing in %s item %0d", name, idx);
                end
                tag = $sformatf("%s item %0d", name, idx);
                if (ntt) begin
                    check_value({tag, " u20"}, expv[idx][0], 64'(u20_o));
                    check_value({tag, " v20"}, expv[idx][1], 64'(v20_o));
                    check_value({tag, " u21"}, expv[idx][2], 64'(u21_o));
                    check_value({tag, " v21"}, expv[idx][3], 64'(v21_o));
                end else begin
                    check_value({tag, " pwo0"}, expv[idx][0], 64'(pwo0_o));
                    check_value({tag, " pwo1"}, expv[idx][1], 64'(pwo1_o));
                    check_value({tag, " pwo2"}, expv[idx][2], 64'(pwo2_o));
                    check_value({tag, " pwo3"}, expv[idx][3], 64'(pwo3_o));
                end
                items_checked++;
            end else if (ready_o) begin
                $display("Regression failed");
                $fatal(1, "ready pulse with no item due in %s", name);
            end
        end
    endtask

    // no ready and every data output at zero
    task automatic check_idle(input string name, input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            if (ready_o) begin
                $display("Regression failed");
                $fatal(1, "ready pulse while idle in %s", name);
            end
            check_value({name, " u20"}, 64'd0, 64'(u20_o));
            check_value({name, " v20"}, 64'd0, 64'(v20_o));
            check_value({name, " u21"}, 64'd0, 64'(u21_o));
            check_value({name, " v21"}, 64'd0, 64'(v21_o));
            check_value({name, " pwo"}, 64'd0, 64'(pwo0_o | pwo1_o | pwo2_o | pwo3_o));
        end
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic test_ct();
        fill_random(20);
        stream_items(ct, 20, "ct");
    endtask

    task automatic test_gs();
        fill_random(20);
        // u below v in both first layer units
        stim[0][0] = 64'd1;
        stim[0][1] = REF_Q - 1;
        stim[0][3] = 64'd0;
        stim[0][4] = 64'd5;
        stream_items(gs, 20, "gs");
    endtask

    task automatic test_pwm();
        fill_random(20);
        set_pair(0, 0, 64'd0, REF_Q - 1);
        set_pair(0, 1, 64'd1, REF_Q - 1);
        set_pair(0, 2, REF_Q - 1, REF_Q - 1);
        set_pair(0, 3, REF_Q - 1, 64'd1);
        stream_items(pwm, 20, "pwm");
    endtask

    task automatic test_pwa_pws();
        fill_random(20);
        set_pair(0, 0, REF_Q - 1, REF_Q - 1);
        set_pair(0, 1, 64'd0, 64'd0);
        set_pair(0, 2, REF_Q - 1, 64'd1);
        set_pair(0, 3, 64'd1, REF_Q - 2);
        stream_items(pwa, 20, "pwa");
        fill_random(20);
        set_pair(0, 0, 64'd0, 64'd1);
        set_pair(0, 1, 64'd0, REF_Q - 1);
        set_pair(0, 2, REF_Q - 1, 64'd0);
        set_pair(0, 3, 64'd5, 64'd5);
        stream_items(pws, 20, "pws");
    endtask

    // six ct items in flight then flushed
    task automatic test_zeroize();
        fill_random(6);
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            drive_item(ct, i);
        end
        @(posedge clk);
        zero_inputs();
        zeroize_i <= 1'b1;
        @(posedge clk);
        zeroize_i <= 1'b0;
        // pwm puts the multiplier registers on the pwo outputs
        mode_i <= pwm;
        check_idle("zeroize", NTT_READY_LAT + 2);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        items_checked = 0;
        cycle_cnt = 0;
        reset_n = 1'b0;
        zeroize_i = 1'b0;
        zero_inputs();
        release_reset();
        mode_i <= pwm;
        check_idle("reset", 4);
        test_ct();
        test_gs();
        test_pwm();
        test_pwa_pws();
        test_zeroize();
        @(posedge clk);
        if (items_checked == 5 * 20) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "only %0d items were checked", items_checked);
        end
    end

endmodule

// ==== filelist.f ====
+incdir+verif
hdl/ntt_pkg.sv
hdl/ntt_operand_if.sv
hdl/ntt_mod_mult.sv
hdl/ntt_butterfly.sv
hdl/ntt_operand_router.sv
hdl/ntt_ready_tracker.sv
hdl/ntt_butterfly_2x2.sv
verif/tb_ntt_butterfly_2x2.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the butterfly testbench with verilator and run it
# exit status is nonzero when the build or the regression fails
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -j 0 \
    -f filelist.f \
    --top-module tb_ntt_butterfly_2x2 \
    && ./obj_dir/Vtb_ntt_butterfly_2x2 \
    || exit 1
